//--- pcie_dma_top.f
+incdir+include
rtl/pcie_dma_pkg.sv
rtl/pcie_dma_ifs.sv
rtl/pcie_rx_tlp_parser.sv
rtl/pcie_bar_ram.sv
rtl/pcie_cpld_tx.sv
rtl/pcie_dma_top.sv
dv/pcie_dma_tb.sv

//--- dv/pcie_dma_tb.sv
// PCIe target engine testbench
`include "pcie_dma_config.svh"

module pcie_dma_tb;
    import pcie_dma_pkg::*;

    // about 60 TLPs of at most 40 cycles each plus margin
    localparam int TIMEOUT_CYCLES = 3000;

    logic        clk;
    logic        rst_n;
    bus_num_t    cfg_bus;
    dev_num_t    cfg_dev;
    logic        m_tvld;
    logic        m_trdy;
    tlp_data_t   m_tdata;
    logic        m_tlast;
    logic        s_trdy;
    logic        s_tvld;
    tlp_data_t   s_tdata;
    logic        s_tlast;
    logic        slave_stall;
    logic [31:0] rng_state = 32'd14;
    int          cycles = 0;
    tlp_data_t   bar_model [0:(2**`PCIE_BAR_ADDR_W)-1];
    tlp_data_t   exp_hdr_q[$];
    tlp_data_t   exp_data_q[$];
    logic [31:0] addr_list[$];

    pcie_dma_top i_dut (
        .clk                (clk),
        .i_rst_n            (rst_n),
        .i_cfg_pbus_num     (cfg_bus),
        .i_cfg_pbus_dev_num (cfg_dev),
        .i_axis_master_tvld (m_tvld),
        .o_axis_master_trdy (m_trdy),
        .i_axis_master_tdata(m_tdata),
        .i_axis_master_tlast(m_tlast),
        .i_axis_slave_trdy  (s_trdy),
        .o_axis_slave_tvld  (s_tvld),
        .o_axis_slave_tdata (s_tdata),
        .o_axis_slave_tlast (s_tlast)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    //******************************
    // helpers
    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic stop_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input tlp_data_t got, input tlp_data_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED time %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // request header with the 32-bit address in DW2
    function automatic tlp_data_t make_req_header(input logic [2:0] fmt, input logic [9:0] len,
            input logic [31:0] addr, input logic [3:0] first_be, input logic [3:0] last_be,
            input req_id_t req_id, input tlp_tag_t tag, input tlp_tc_t tc, input tlp_attr_t attr);
        tlp_data_t h;
        h = '0;
        h[31:29] = fmt;
        h[28:24] = `PCIE_TYPE_MEM;
        h[22:20] = tc;
        h[13:12] = attr;
        h[9:0]   = len;
        h[63:48] = req_id;
        h[47:40] = tag;
        h[39:36] = last_be;
        h[35:32] = first_be;
        h[95:64] = addr;
        return h;
    endfunction

    function automatic tlp_data_t make_cpl_header(input logic [31:0] addr, input req_id_t req_id,
            input tlp_tag_t tag, input tlp_tc_t tc, input tlp_attr_t attr);
        tlp_data_t h;
        h = '0;
        h[31:29] = `PCIE_FMT_CPLD;
        h[28:24] = `PCIE_TYPE_CPL;
        h[22:20] = tc;
        h[13:12] = attr;
        h[9:0]   = 10'd4;
        // completer id with function 0
        h[63:48] = {cfg_bus, cfg_dev, 3'b000};
        h[43:32] = 12'd16;
        h[95:80] = req_id;
        h[79:72] = tag;
        h[70:64] = addr[6:0];
        return h;
    endfunction

    //******************************
    // stream tasks start and end on a falling edge
    task automatic send_beat(input tlp_data_t data, input logic last);
        m_tvld  = 1'b1;
        m_tdata = data;
        m_tlast = last;
        while (!m_trdy)
            @(negedge clk);
        // trdy holds through the rising edge
        @(negedge clk);
    endtask

    task automatic send_mwr(input logic [31:0] addr, input tlp_data_t data,
            input logic [3:0] first_be, input logic [3:0] last_be);
        logic en;
        send_beat(make_req_header(`PCIE_FMT_MWR32, 10'd4, addr, first_be, last_be,
                                  16'h0, 8'h0, 3'h0, 2'h0), 1'b0);
        send_beat(data, 1'b1);
        m_tvld = 1'b0;
        for (int i = 0; i < `PCIE_BE_W; i++)
        begin
            if (i < 4)
                en = first_be[i];
            else if (i >= 12)
                en = last_be[i-12];
            else
                en = 1'b1;
            if (en)
                bar_model[addr[11:4]][i*8 +: 8] = data[i*8 +: 8];
        end
    endtask

    task automatic send_mrd(input logic [31:0] addr, input req_id_t req_id,
            input tlp_tag_t tag, input tlp_tc_t tc, input tlp_attr_t attr);
        exp_hdr_q.push_back(make_cpl_header(addr, req_id, tag, tc, attr));
        exp_data_q.push_back(bar_model[addr[11:4]]);
        send_beat(make_req_header(`PCIE_FMT_MRD32, 10'd4, addr, 4'hf, 4'hf,
                                  req_id, tag, tc, attr), 1'b1);
        m_tvld = 1'b0;
    endtask

    task automatic take_beat(input tlp_data_t exp, input logic last);
        logic        done;
        logic        stalled;
        logic [31:0] r;
        done    = 1'b0;
        stalled = 1'b0;
        while (!done)
        begin
            // a stalled beat must still be offered
            if (stalled)
                check_bit("o_axis_slave_tvld", s_tvld, 1'b1);
            r      = next_random();
            s_trdy = !slave_stall || r[0] || r[1];
            if (s_tvld)
            begin
                check_data("o_axis_slave_tdata", s_tdata, exp);
                check_bit("o_axis_slave_tlast", s_tlast, last);
                done = s_trdy;
            end
            stalled = s_tvld && !s_trdy;
            @(negedge clk);
        end
    endtask

    task automatic expect_cpld();
        while (exp_hdr_q.size() == 0)
            @(negedge clk);
        take_beat(exp_hdr_q.pop_front(), 1'b0);
        take_beat(exp_data_q.pop_front(), 1'b1);
    endtask

    //******************************
    // directed tests
    initial
    begin
        logic [31:0] r;
        logic [31:0] addr;
        tlp_data_t   data;
        rst_n       = 1'b0;
        cfg_bus     = 8'h3c;
        cfg_dev     = 5'h0b;
        m_tvld      = 1'b0;
        m_tdata     = '0;
        m_tlast     = 1'b0;
        s_trdy      = 1'b1;
        slave_stall = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("o_axis_slave_tvld", s_tvld, 1'b0);
        check_bit("o_axis_master_trdy", m_trdy, 1'b1);

        // full write then read
        send_mwr(32'h0000_0120, 128'h0f0e0d0c_0b0a0908_07060504_03020100, 4'hf, 4'hf);
        send_mrd(32'h0000_0120, 16'h0102, 8'h11, 3'd5, 2'd2);
        expect_cpld();

        // partial write merges into the old entry
        send_mwr(32'h0000_0350, 128'h11111111_22222222_33333333_44444444, 4'hf, 4'hf);
        send_mwr(32'h0000_0350, 128'haaaaaaaa_bbbbbbbb_cccccccc_dddddddd, 4'h6, 4'h9);
        send_mrd(32'h0000_0350, 16'h0a0b, 8'h22, 3'd1, 2'd1);
        expect_cpld();

        // random pairs with back-pressure on the completion stream
        slave_stall = 1'b1;
        repeat (12)
        begin
            r    = next_random();
            addr = {r[31:4], 4'h0};
            data = {next_random(), next_random(), next_random(), next_random()};
            addr_list.push_back(addr);
            send_mwr(addr, data, 4'hf, 4'hf);
            r = next_random();
            send_mrd(addr, r[15:0], r[23:16], r[26:24], r[28:27]);
            expect_cpld();
        end

        // reads without gaps while completions are taken in parallel
        fork
            for (int i = 0; i < 6; i++)
                send_mrd(addr_list[i], 16'h0200 + 16'(i), 8'h40 + 8'(i), 3'd0, 2'd0);
            repeat (6) expect_cpld();
        join

        // unsupported writes leave the entry unchanged
        send_beat(make_req_header(`PCIE_FMT_MWR32, 10'd8, 32'h0000_0120, 4'hf, 4'hf,
                                  16'h0, 8'h0, 3'h0, 2'h0), 1'b0);
        send_beat({4{32'hdeadbeef}}, 1'b0);
        send_beat({4{32'hfeedface}}, 1'b1);
        send_beat(make_req_header(3'b011, 10'd4, 32'h0000_0120, 4'hf, 4'hf,
                                  16'h0, 8'h0, 3'h0, 2'h0), 1'b0);
        send_beat({4{32'h5a5a5a5a}}, 1'b1);
        m_tvld = 1'b0;
        send_mrd(32'h0000_0120, 16'h0303, 8'h77, 3'd2, 2'd3);
        expect_cpld();

        $display("No errors");
        $finish;
    end

endmodule

//--- rtl/pcie_dma_top.sv
// PCIe target engine top

module pcie_dma_top (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  pcie_dma_pkg::bus_num_t  i_cfg_pbus_num,
    input  pcie_dma_pkg::dev_num_t  i_cfg_pbus_dev_num,
    // axis master, requests in
    input  logic                    i_axis_master_tvld,
    output logic                    o_axis_master_trdy,
    input  pcie_dma_pkg::tlp_data_t i_axis_master_tdata,
    input  logic                    i_axis_master_tlast,
    // axis slave, completions out
    input  logic                    i_axis_slave_trdy,
    output logic                    o_axis_slave_tvld,
    output pcie_dma_pkg::tlp_data_t o_axis_slave_tdata,
    output logic                    o_axis_slave_tlast
);
    import pcie_dma_pkg::*;

    logic      bar_rd_en;
    bar_addr_t bar_rd_addr;
    tlp_data_t bar_rd_data;

    bar_wr_if  u_bar_wr ();
    cpl_req_if u_cpl_req ();

    //******************************
    // rx side
    pcie_rx_tlp_parser u_pcie_rx_tlp_parser (
        .clk                 (clk),
        .i_rst_n             (i_rst_n),
        .i_axis_master_tvld  (i_axis_master_tvld),
        .i_axis_master_tdata (i_axis_master_tdata),
        .i_axis_master_tlast (i_axis_master_tlast),
        .o_axis_master_trdy  (o_axis_master_trdy),
        .bar_wr              (u_bar_wr.writer),
        .cpl_req             (u_cpl_req.requester)
    );

    pcie_bar_ram u_pcie_bar_ram (
        .clk       (clk),
        .i_rd_en   (bar_rd_en),
        .i_rd_addr (bar_rd_addr),
        .o_rd_data (bar_rd_data),
        .bar_wr    (u_bar_wr.memory)
    );

    //******************************
    // tx side
    pcie_cpld_tx u_pcie_cpld_tx (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_cfg_pbus_num     (i_cfg_pbus_num),
        .i_cfg_pbus_dev_num (i_cfg_pbus_dev_num),
        .i_rd_data          (bar_rd_data),
        .i_axis_slave_trdy  (i_axis_slave_trdy),
        .o_rd_en            (bar_rd_en),
        .o_rd_addr          (bar_rd_addr),
        .o_axis_slave_tvld  (o_axis_slave_tvld),
        .o_axis_slave_tdata (o_axis_slave_tdata),
        .o_axis_slave_tlast (o_axis_slave_tlast),
        .cpl_req            (u_cpl_req.completer)
    );

endmodule

//--- rtl/pcie_cpld_tx.sv
// PCIe completion transmitter
`include "pcie_dma_config.svh"

module pcie_cpld_tx (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  pcie_dma_pkg::bus_num_t  i_cfg_pbus_num,
    input  pcie_dma_pkg::dev_num_t  i_cfg_pbus_dev_num,
    input  pcie_dma_pkg::tlp_data_t i_rd_data,
    input  logic                    i_axis_slave_trdy,
    output logic                    o_rd_en,
    output pcie_dma_pkg::bar_addr_t o_rd_addr,
    output logic                    o_axis_slave_tvld,
    output pcie_dma_pkg::tlp_data_t o_axis_slave_tdata,
    output logic                    o_axis_slave_tlast,
    cpl_req_if.completer            cpl_req
);
    import pcie_dma_pkg::*;

    tx_state_t   state;
    bar_addr_t   bar_addr_q;
    req_id_t     req_id_q;
    tlp_tag_t    tag_q;
    tlp_tc_t     tc_q;
    tlp_attr_t   attr_q;
    lower_addr_t lower_addr_q;
    req_id_t     cpl_id;
    logic [31:0] dw0;
    logic [31:0] dw1;
    logic [31:0] dw2;

    assign cpl_req.rdy = (state == IDLE);
    assign o_rd_en     = (state == READ);
    assign o_rd_addr   = bar_addr_q;

    //******************************
    // completion header
    // function number is always 0
    assign cpl_id = {i_cfg_pbus_num, i_cfg_pbus_dev_num, 3'b000};
    assign dw0    = {`PCIE_FMT_CPLD, `PCIE_TYPE_CPL, 1'b0, tc_q, 4'b0000,
                     2'b00, attr_q, 2'b00, 10'(`PCIE_REQ_LEN_DW)};
    // status successful, BCM clear
    assign dw1    = {cpl_id, 3'b000, 1'b0, 12'(`PCIE_CPL_BYTE_CNT)};
    assign dw2    = {req_id_q, tag_q, 1'b0, lower_addr_q};

    assign o_axis_slave_tvld  = (state == HDR) || (state == DATA);
    assign o_axis_slave_tlast = (state == DATA);
    assign o_axis_slave_tdata = (state == DATA) ? i_rd_data : {32'h0, dw2, dw1, dw0};

    //******************************
    // completion FSM
    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:
                    if (cpl_req.vld)
                        state <= READ;
                READ:
                    state <= HDR;
                HDR:
                    if (i_axis_slave_trdy)
                        state <= DATA;
                DATA:
                    if (i_axis_slave_trdy)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // request fields, taken on the handshake
    always_ff @(posedge clk)
    begin
        if (cpl_req.vld && cpl_req.rdy)
        begin
            bar_addr_q   <= cpl_req.bar_addr;
            req_id_q     <= cpl_req.req_id;
            tag_q        <= cpl_req.tag;
            tc_q         <= cpl_req.tc;
            attr_q       <= cpl_req.attr;
            lower_addr_q <= cpl_req.lower_addr;
        end
    end

    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_axis_slave_tvld && !i_axis_slave_trdy |=> o_axis_slave_tvld &&
        $stable(o_axis_slave_tdata) && $stable(o_axis_slave_tlast));

endmodule

//--- rtl/pcie_bar_ram.sv
// BAR memory
`include "pcie_dma_config.svh"

module pcie_bar_ram (
    input  logic                    clk,
    input  logic                    i_rd_en,
    input  pcie_dma_pkg::bar_addr_t i_rd_addr,
    output pcie_dma_pkg::tlp_data_t o_rd_data,
    bar_wr_if.memory                bar_wr
);
    import pcie_dma_pkg::*;

    tlp_data_t mem [0:(2**`PCIE_BAR_ADDR_W)-1];

    //******************************
    // byte enabled write port
    always_ff @(posedge clk)
    begin
        if (bar_wr.en)
        begin
            for (int i = 0; i < `PCIE_BE_W; i++)
            begin
                if (bar_wr.byte_en[i])
                    mem[bar_wr.addr][i*8 +: 8] <= bar_wr.data[i*8 +: 8];
            end
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk)
    begin
        if (i_rd_en)
            o_rd_data <= mem[i_rd_addr];
    end

endmodule

//--- rtl/pcie_rx_tlp_parser.sv
// PCIe request TLP parser
`include "pcie_dma_config.svh"

module pcie_rx_tlp_parser (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_axis_master_tvld,
    input  pcie_dma_pkg::tlp_data_t i_axis_master_tdata,
    input  logic                    i_axis_master_tlast,
    output logic                    o_axis_master_trdy,
    bar_wr_if.writer                bar_wr,
    cpl_req_if.requester            cpl_req
);
    import pcie_dma_pkg::*;

    rx_state_t  state;
    logic       beat;
    logic [2:0] hdr_fmt;
    logic [4:0] hdr_type;
    logic [9:0] hdr_len;
    logic       is_mwr;
    logic       is_mrd;

    //******************************
    // header decode, DW0 fields
    assign hdr_fmt  = i_axis_master_tdata[31:29];
    assign hdr_type = i_axis_master_tdata[28:24];
    assign hdr_len  = i_axis_master_tdata[9:0];

    assign is_mwr = (hdr_fmt == `PCIE_FMT_MWR32) && (hdr_type == `PCIE_TYPE_MEM) &&
                    (hdr_len == 10'(`PCIE_REQ_LEN_DW));
    assign is_mrd = (hdr_fmt == `PCIE_FMT_MRD32) && (hdr_type == `PCIE_TYPE_MEM) &&
                    (hdr_len == 10'(`PCIE_REQ_LEN_DW));

    // stall the stream while a read waits for the transmitter
    assign o_axis_master_trdy = (state != CPL_WAIT);
    assign beat               = i_axis_master_tvld && o_axis_master_trdy;

    //******************************
    // request FSM
    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            state       <= HEADER;
            bar_wr.en   <= 1'b0;
            cpl_req.vld <= 1'b0;
        end
        else
        begin
            bar_wr.en <= 1'b0;
            case (state)
                HEADER:
                    if (beat)
                    begin
                        if (is_mwr && !i_axis_master_tlast)
                            state <= WR_DATA;
                        else if (is_mrd && i_axis_master_tlast)
                        begin
                            cpl_req.vld <= 1'b1;
                            state       <= CPL_WAIT;
                        end
                        else if (!i_axis_master_tlast)
                            state <= DISCARD;
                    end
                WR_DATA:
                    if (beat)
                    begin
                        bar_wr.en <= 1'b1;
                        state     <= i_axis_master_tlast ? HEADER : DISCARD;
                    end
                CPL_WAIT:
                    if (cpl_req.rdy)
                    begin
                        cpl_req.vld <= 1'b0;
                        state       <= HEADER;
                    end
                DISCARD:
                    if (beat && i_axis_master_tlast)
                        state <= HEADER;
                default:
                    state <= HEADER;
            endcase
        end
    end

    // header fields, DW1 and DW2
    always_ff @(posedge clk)
    begin
        if (state == HEADER && beat)
        begin
            bar_wr.addr        <= i_axis_master_tdata[68 +: `PCIE_BAR_ADDR_W];
            // first BE on the low DW, last BE on the high DW
            bar_wr.byte_en     <= {i_axis_master_tdata[39:36], 8'hff,
                                   i_axis_master_tdata[35:32]};
            cpl_req.bar_addr   <= i_axis_master_tdata[68 +: `PCIE_BAR_ADDR_W];
            cpl_req.req_id     <= i_axis_master_tdata[63:48];
            cpl_req.tag        <= i_axis_master_tdata[47:40];
            cpl_req.tc         <= i_axis_master_tdata[22:20];
            cpl_req.attr       <= i_axis_master_tdata[13:12];
            cpl_req.lower_addr <= i_axis_master_tdata[70:64];
        end
        if (state == WR_DATA && beat)
            bar_wr.data <= i_axis_master_tdata;
    end

    // a data beat is always followed by a header beat
    assert property (@(posedge clk) disable iff (!i_rst_n) bar_wr.en |=> !bar_wr.en);

    assert property (@(posedge clk) disable iff (!i_rst_n)
        cpl_req.vld && !cpl_req.rdy |=> cpl_req.vld &&
        $stable({cpl_req.bar_addr, cpl_req.req_id, cpl_req.tag,
                 cpl_req.tc, cpl_req.attr, cpl_req.lower_addr}));

endmodule

//--- rtl/pcie_dma_ifs.sv
// BAR write and completion request interfaces

// byte enabled write strobe into the BAR, no handshake
interface bar_wr_if;
    import pcie_dma_pkg::*;

    logic      en;
    bar_addr_t addr;
    tlp_data_t data;
    byte_en_t  byte_en;

    modport writer (output en, output addr, output data, output byte_en);
    modport memory (input en, input addr, input data, input byte_en);
endinterface

// read completion request, rx to tx
interface cpl_req_if;
    import pcie_dma_pkg::*;

    logic        vld;
    logic        rdy;
    bar_addr_t   bar_addr;
    req_id_t     req_id;
    tlp_tag_t    tag;
    tlp_tc_t     tc;
    tlp_attr_t   attr;
    lower_addr_t lower_addr;

    modport requester (
        output vld, output bar_addr, output req_id, output tag,
        output tc, output attr, output lower_addr,
        input  rdy
    );
    modport completer (
        input  vld, input bar_addr, input req_id, input tag,
        input  tc, input attr, input lower_addr,
        output rdy
    );
endinterface

//--- rtl/pcie_dma_pkg.sv
// PCIe target engine types
`include "pcie_dma_config.svh"

package pcie_dma_pkg;

    //******************************
    // payload and address vectors
    typedef logic [`PCIE_DATA_W-1:0]     tlp_data_t;
    typedef logic [`PCIE_BE_W-1:0]       byte_en_t;
    typedef logic [`PCIE_BAR_ADDR_W-1:0] bar_addr_t;

    //******************************
    // tlp header fields
    typedef logic [15:0] req_id_t;
    typedef logic [7:0]  tlp_tag_t;
    typedef logic [2:0]  tlp_tc_t;
    typedef logic [1:0]  tlp_attr_t;
    // address bits 6..0 echoed in the completion
    typedef logic [6:0]  lower_addr_t;

    // config space ids
    typedef logic [7:0]  bus_num_t;
    typedef logic [4:0]  dev_num_t;

    //******************************
    // state machines
    typedef enum logic [1:0] {
        HEADER,
        WR_DATA,
        CPL_WAIT,
        DISCARD
    } rx_state_t;

    // one completion in flight
    typedef enum logic [1:0] {
        IDLE,
        READ,
        HDR,
        DATA
    } tx_state_t;

endpackage

//--- include/pcie_dma_config.svh
// PCIe target engine configuration
`ifndef PCIE_DMA_CONFIG_SVH
`define PCIE_DMA_CONFIG_SVH

//******************************
// datapath widths
`define PCIE_DATA_W         128
`define PCIE_BE_W           16
// 256 entries of 16 bytes
`define PCIE_BAR_ADDR_W     8

//******************************
// tlp fmt and type codes
`define PCIE_FMT_MWR32      3'b010
`define PCIE_FMT_MRD32      3'b000
`define PCIE_FMT_CPLD       3'b010
`define PCIE_TYPE_MEM       5'b00000
`define PCIE_TYPE_CPL       5'b01010

// only 4 DW requests are served
`define PCIE_REQ_LEN_DW     4
`define PCIE_CPL_BYTE_CNT   16

`endif
